// File: all.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_excp_capture.sv
verilog/csr_timer.sv
verilog/csr_regfile.sv
verilog/csr_top.sv
tests/csr_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the CSR unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module csr_tb -o csr_sim \
    && ./obj_dir/csr_sim | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tests/csr_tb.sv
`default_nettype none
`include "csr_macros.svh"

module csr_tb;
    import csr_pkg::*;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 16;
    // Cycle budget per test
    localparam int MAP_CYCLES = 8;
    localparam int RW_CYCLES = 40;
    localparam int EXCP_CYCLES = 24;
    localparam int CONFLICT_CYCLES = 12;
    localparam int TIMER_CYCLES = 120;
    localparam int HW_CYCLES = 64;
    localparam int MARGIN_CYCLES = 64;
    localparam int TOTAL_CYCLES = RESET_CYCLES + MAP_CYCLES + RW_CYCLES + EXCP_CYCLES
        + CONFLICT_CYCLES + TIMER_CYCLES + HW_CYCLES + MARGIN_CYCLES;

    logic       clk;
    logic       rst;
    csr_addr_t  rd_addr1;
    csr_addr_t  rd_addr2;
    csr_addr_t  waddr;
    logic       wen;
    csr_word_t  wdata;
    logic       in_excp;
    logic       is_ertn;
    ecode_t     excp_ecode;
    esubcode_t  excp_subcode;
    csr_word_t  excp_era;
    logic       use_badv;
    csr_word_t  bad_vaddr;
    logic [7:0] intrpt;
    csr_word_t  rd_data1;
    csr_word_t  rd_data2;
    logic       excp_jump;
    csr_word_t  excp_pc;
    logic       jump_excp_fail;
    logic       have_intrpt;

    int        errors = 0;
    // Expected ERA and ESTAT carried from the exception test
    csr_word_t era_model;
    csr_word_t estat_model;

    csr_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .rd_addr1       (rd_addr1),
        .rd_addr2       (rd_addr2),
        .waddr          (waddr),
        .wen            (wen),
        .wdata          (wdata),
        .in_excp        (in_excp),
        .is_ertn        (is_ertn),
        .excp_ecode     (excp_ecode),
        .excp_subcode   (excp_subcode),
        .excp_era       (excp_era),
        .use_badv       (use_badv),
        .bad_vaddr      (bad_vaddr),
        .intrpt         (intrpt),
        .rd_data1       (rd_data1),
        .rd_data2       (rd_data2),
        .excp_jump      (excp_jump),
        .excp_pc        (excp_pc),
        .jump_excp_fail (jump_excp_fail),
        .have_intrpt    (have_intrpt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual)
        begin
            errors++;
            $display("error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    // Both read ports on one address, in the low clock phase
    task automatic read_check(input csr_addr_t addr, input csr_word_t expected,
                              input string name);
        rd_addr1 = addr;
        rd_addr2 = addr;
        #1;
        check({name, " rd_data1"}, expected, rd_data1);
        check({name, " rd_data2"}, expected, rd_data2);
    endtask

    // Returns at the falling edge after the write took effect
    task automatic write_csr(input csr_addr_t addr, input csr_word_t data);
        @(negedge clk);
        wen = 1'b1;
        waddr = addr;
        wdata = data;
        @(negedge clk);
        wen = 1'b0;
    endtask

    task automatic wait_timer_irq(input int bound);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < bound)
        begin
            @(negedge clk);
            rd_addr1 = `ESTAT;
            #1;
            seen = rd_data1[11];
            n++;
        end
        if (!seen)
        begin
            errors++;
            $display("timer interrupt status did not set within %0d cycles", bound);
        end
    endtask

    task automatic reset_map_values;
        @(negedge clk);
        read_check(`CRMD, `CRMD_RESET, "crmd");
        read_check(`PRMD, '0, "prmd");
        read_check(`ESTAT, '0, "estat");
        read_check(`ERA, '0, "era");
        read_check(`BADV, '0, "badv");
        read_check(`EENTRY, '0, "eentry");
        read_check(`ECFG, '0, "ecfg");
        read_check(`TID, '0, "tid");
        @(negedge clk);
        read_check(`SAVE0, '0, "save0");
        read_check(`SAVE1, '0, "save1");
        read_check(`SAVE2, '0, "save2");
        read_check(`SAVE3, '0, "save3");
        read_check(`TCFG, '0, "tcfg");
        read_check(`TVAL, '0, "tval");
        read_check(14'h0002, '0, "unmapped 0x002");
        read_check(14'h3fff, '0, "unmapped 0x3fff");
        check("have_intrpt", 0, have_intrpt);
        check("excp_jump", 0, excp_jump);
        check("jump_excp_fail", 0, jump_excp_fail);
    endtask

    task automatic write_readback;
        csr_addr_t addrs [7];
        csr_word_t val;
        csr_word_t expected;
        addrs = '{`SAVE0, `SAVE1, `SAVE2, `SAVE3, `TID, `ERA, `EENTRY};
        for (int i = 0; i < 7; i++)
        begin
            val = $urandom;
            // EENTRY holds only the VA field
            expected = (addrs[i] == `EENTRY) ? (val & 32'hffff_ffc0) : val;
            write_csr(addrs[i], val);
            read_check(addrs[i], expected, $sformatf("csr 0x%03h", addrs[i]));
        end
        val = $urandom;
        write_csr(`ESTAT, val);
        read_check(`ESTAT, {30'b0, val[1:0]}, "estat soft bits");
        write_csr(`ESTAT, '0);
        read_check(`ESTAT, '0, "estat cleared");
    endtask

    task automatic exception_and_return;
        csr_word_t entry;
        csr_word_t badv_val;
        ecode_t    code;
        esubcode_t sub;
        entry = $urandom & 32'hffff_ffc0;
        era_model = $urandom;
        badv_val = $urandom;
        code = 6'h0b;
        sub = 9'h003;
        write_csr(`EENTRY, entry);
        // PLV 3, IE set, DA set
        write_csr(`CRMD, 32'h0000_000f);
        in_excp = 1'b1;
        excp_ecode = code;
        excp_subcode = sub;
        excp_era = era_model;
        use_badv = 1'b1;
        bad_vaddr = badv_val;
        #1;
        check("excp_jump on exception", 1, excp_jump);
        check("excp_pc on exception", entry, excp_pc);
        check("jump_excp_fail on exception", 0, jump_excp_fail);
        @(negedge clk);
        in_excp = 1'b0;
        use_badv = 1'b0;
        estat_model = {1'b0, sub, code, 16'h0000};
        read_check(`CRMD, 32'h0000_0008, "crmd after exception");
        read_check(`PRMD, 32'h0000_0007, "prmd after exception");
        read_check(`ESTAT, estat_model, "estat after exception");
        read_check(`ERA, era_model, "era after exception");
        read_check(`BADV, badv_val, "badv after exception");
        @(negedge clk);
        is_ertn = 1'b1;
        #1;
        check("excp_jump on return", 1, excp_jump);
        check("excp_pc on return", era_model, excp_pc);
        @(negedge clk);
        is_ertn = 1'b0;
        read_check(`CRMD, 32'h0000_000f, "crmd after return");
    endtask

    task automatic write_conflict;
        csr_word_t save_val;
        save_val = $urandom;
        @(negedge clk);
        in_excp = 1'b1;
        excp_ecode = 6'h09;
        excp_subcode = 9'h001;
        excp_era = $urandom;
        wen = 1'b1;
        waddr = `SAVE1;
        wdata = save_val;
        #1;
        check("jump_excp_fail on conflict", 1, jump_excp_fail);
        check("excp_jump on conflict", 0, excp_jump);
        @(negedge clk);
        in_excp = 1'b0;
        wen = 1'b0;
        read_check(`SAVE1, save_val, "save1 after conflict");
        read_check(`ERA, era_model, "era after conflict");
        read_check(`ESTAT, estat_model, "estat after conflict");
    endtask

    task automatic timer_sequence;
        csr_word_t t0;
        csr_word_t t1;
        int        gap;
        write_csr(`ECFG, 32'h0000_0800);
        // One-shot, INITVAL 3
        write_csr(`TCFG, {30'd3, 2'b01});
        rd_addr1 = `TVAL;
        #1;
        check("tval after load", 32'd12, rd_data1);
        @(negedge clk);
        #1;
        check("tval one cycle later", 32'd11, rd_data1);
        wait_timer_irq(3 * 4 + 3);
        check("have_intrpt from timer", 1, have_intrpt);
        write_csr(`TICLR, 32'h1);
        rd_addr1 = `ESTAT;
        #1;
        check("estat.is_ti after clear", 0, rd_data1[11]);
        check("have_intrpt after clear", 0, have_intrpt);

        // Periodic, INITVAL 2
        write_csr(`TCFG, {30'd2, 2'b11});
        wait_timer_irq(2 * 4 + 3);
        write_csr(`TICLR, 32'h1);
        rd_addr1 = `ESTAT;
        #1;
        check("estat.is_ti periodic clear", 0, rd_data1[11]);
        wait_timer_irq(2 * 4 + 3);
        write_csr(`TCFG, '0);
        write_csr(`TICLR, 32'h1);
        rd_addr1 = `ESTAT;
        #1;
        check("estat.is_ti after stop", 0, rd_data1[11]);

        gap = 10 + int'($urandom % 20);
        rd_addr1 = `TIMER_64_L;
        #1;
        t0 = rd_data1;
        repeat (gap) @(negedge clk);
        #1;
        t1 = rd_data1;
        check("timer_64 delta", gap, t1 - t0);
    endtask

    task automatic hw_interrupt_lines;
        logic [7:0]  hw;
        logic [7:0]  prev_hw;
        logic [12:0] lie;
        logic        ie;
        logic        exp_irq;
        prev_hw = 8'h00;
        for (int i = 0; i < 8; i++)
        begin
            hw = 8'($urandom);
            lie = 13'($urandom);
            // IE off in every third round
            ie = (i % 3) != 2;
            if (i == 0)
            begin
                hw = 8'h10;
                lie = 13'h0040;
            end
            if (i == 1)
            begin
                hw = 8'hff;
                lie = 13'h1803;
            end
            write_csr(`CRMD, {28'h0, 1'b1, ie, 2'b00});
            write_csr(`ECFG, {19'b0, lie});
            intrpt = hw;
            rd_addr1 = `ESTAT;
            #1;
            check("estat.is_hard before sample", prev_hw, rd_data1[9:2]);
            @(negedge clk);
            #1;
            check("estat.is_hard", hw, rd_data1[9:2]);
            exp_irq = ie && |(lie & {3'b000, hw, 2'b00});
            check("have_intrpt", exp_irq, have_intrpt);
            prev_hw = hw;
        end

        // Clearing IE masks an enabled line
        intrpt = 8'hff;
        write_csr(`ECFG, 32'h0000_1fff);
        #1;
        check("have_intrpt all enabled", 1, have_intrpt);
        write_csr(`CRMD, 32'h0000_0008);
        #1;
        check("have_intrpt with ie clear", 0, have_intrpt);
        intrpt = 8'h00;
    endtask

    initial
    begin
        #(CLK_PERIOD * TOTAL_CYCLES);
        $display("watchdog expired after %0d cycles before the tests finished", TOTAL_CYCLES);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        clk = 1'b0;
        rst = 1'b1;
        rd_addr1 = '0;
        rd_addr2 = '0;
        waddr = '0;
        wen = 1'b0;
        wdata = '0;
        in_excp = 1'b0;
        is_ertn = 1'b0;
        excp_ecode = '0;
        excp_subcode = '0;
        excp_era = '0;
        use_badv = 1'b0;
        bad_vaddr = '0;
        intrpt = '0;
        era_model = '0;
        estat_model = '0;
        void'($urandom(74518));
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        reset_map_values();
        write_readback();
        exception_and_return();
        write_conflict();
        timer_sequence();
        hw_interrupt_lines();

        $display("Errors: %0d", errors);
        if (errors == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/csr_excp_capture.sv
`default_nettype none

module csr_excp_capture (
    input  logic clk,
    input  logic rst,
    input  logic wen,
    input  logic in_excp,
    input  logic is_ertn,
    output logic excp_commit,
    output logic ertn_commit,
    output logic jump_excp_fail,
    output logic excp_jump
);

    // A CSR write in the same cycle wins over the exception
    assign jump_excp_fail = wen && in_excp;

    assign excp_commit = in_excp && !wen;

    // Exception has priority over a return
    assign ertn_commit = is_ertn && !in_excp && !wen;

    // Redirect only for an accepted event
    assign excp_jump = excp_commit || ertn_commit;

    a_commit_onehot: assert property (
        @(posedge clk) !(excp_commit && ertn_commit)
    ) else $error("exception and return committed together");

    a_no_commit_in_reset: assert property (
        @(posedge clk) rst |-> !excp_commit && !ertn_commit
    ) else $error("commit strobe during reset");

endmodule

`default_nettype wire

// File: verilog/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// CSR numbers
`define CRMD        14'h0000
`define PRMD        14'h0001
`define ECFG        14'h0004
`define ESTAT       14'h0005
`define ERA         14'h0006
`define BADV        14'h0007
`define EENTRY      14'h000c
`define SAVE0       14'h0030
`define SAVE1       14'h0031
`define SAVE2       14'h0032
`define SAVE3       14'h0033
`define TID         14'h0040
`define TCFG        14'h0041
`define TVAL        14'h0042
`define TICLR       14'h0044
// Stable counter halves in local numbering
`define TIMER_64_L  14'h0100
`define TIMER_64_H  14'h0101

// CRMD fields
`define PLV         1:0
`define IE          2
`define DA          3
`define PG          4
`define DATF        6:5
`define DATM        8:7

// PRMD fields
`define PPLV        1:0
`define PIE         2

// ESTAT fields
`define IS_SOFT     1:0
`define IS_HARD     9:2
`define IS_TI       11
`define ECODE       21:16
`define ESUBCODE    30:22

// ECFG local interrupt enables
`define LIE_9_0     9:0
`define LIE_12_11   12:11
// Interrupt status and enable bits shared by ESTAT and ECFG
`define INT_VEC     12:0

// TCFG fields
`define EN          0
`define PERIODIC    1
`define INITVAL     31:2

`define CLR         0
`define VA          31:6

// Direct address mode only
`define CRMD_RESET  32'h0000_0008

`endif

// File: verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // One CSR data word
    typedef logic [31:0] csr_word_t;

    // CSR number as carried by csrrd/csrwr
    typedef logic [13:0] csr_addr_t;

    // Exception code and subcode as stored in ESTAT
    typedef logic [5:0] ecode_t;
    typedef logic [8:0] esubcode_t;

endpackage

`default_nettype wire

// File: verilog/csr_regfile.sv
`default_nettype none
`include "csr_macros.svh"

module csr_regfile (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::csr_addr_t  rd_addr1,
    input  csr_pkg::csr_addr_t  rd_addr2,
    input  logic                wen,
    input  csr_pkg::csr_addr_t  waddr,
    input  csr_pkg::csr_word_t  wdata,
    input  logic                excp_commit,
    input  logic                ertn_commit,
    input  logic                excp_jump,
    input  csr_pkg::ecode_t     excp_ecode,
    input  csr_pkg::esubcode_t  excp_subcode,
    input  csr_pkg::csr_word_t  excp_era,
    input  logic                use_badv,
    input  csr_pkg::csr_word_t  bad_vaddr,
    input  logic [7:0]          intrpt,
    input  csr_pkg::csr_word_t  tcfg,
    input  csr_pkg::csr_word_t  tval,
    input  logic [63:0]         timer_64,
    input  logic                ti_fire,
    output csr_pkg::csr_word_t  rd_data1,
    output csr_pkg::csr_word_t  rd_data2,
    output logic                tcfg_we,
    output csr_pkg::csr_word_t  excp_pc,
    output logic                have_intrpt
);
    import csr_pkg::*;

    csr_word_t crmd;
    csr_word_t prmd;
    csr_word_t estat;
    csr_word_t era;
    csr_word_t eentry;
    csr_word_t ecfg;
    csr_word_t tid;
    csr_word_t badv;
    csr_word_t save [4];

    logic we_crmd;
    logic we_prmd;
    logic we_estat;
    logic we_era;
    logic we_eentry;
    logic we_ecfg;
    logic we_tid;
    logic ti_clear;

    assign we_crmd = wen && (waddr == `CRMD);
    assign we_prmd = wen && (waddr == `PRMD);
    assign we_estat = wen && (waddr == `ESTAT);
    assign we_era = wen && (waddr == `ERA);
    assign we_eentry = wen && (waddr == `EENTRY);
    assign we_ecfg = wen && (waddr == `ECFG);
    assign we_tid = wen && (waddr == `TID);
    assign tcfg_we = wen && (waddr == `TCFG);
    assign ti_clear = wen && (waddr == `TICLR) && wdata[`CLR];

    assign excp_pc = excp_commit ? eentry : era;
    assign have_intrpt = crmd[`IE] && |(ecfg[`INT_VEC] & estat[`INT_VEC]);

    function automatic csr_word_t csr_read(input csr_addr_t addr);
        case (addr)
            `CRMD:       csr_read = crmd;
            `PRMD:       csr_read = prmd;
            `ESTAT:      csr_read = estat;
            `ERA:        csr_read = era;
            `BADV:       csr_read = badv;
            `EENTRY:     csr_read = eentry;
            `SAVE0:      csr_read = save[0];
            `SAVE1:      csr_read = save[1];
            `SAVE2:      csr_read = save[2];
            `SAVE3:      csr_read = save[3];
            `ECFG:       csr_read = ecfg;
            `TID:        csr_read = tid;
            `TCFG:       csr_read = tcfg;
            `TVAL:       csr_read = tval;
            `TIMER_64_L: csr_read = timer_64[31:0];
            `TIMER_64_H: csr_read = timer_64[63:32];
            default:     csr_read = '0;
        endcase
    endfunction

    always_comb
    begin
        rd_data1 = csr_read(rd_addr1);
        rd_data2 = csr_read(rd_addr2);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            crmd <= `CRMD_RESET;
        end
        else if (we_crmd)
        begin
            crmd[`PLV] <= wdata[`PLV];
            crmd[`IE] <= wdata[`IE];
            crmd[`DA] <= wdata[`DA];
            crmd[`PG] <= wdata[`PG];
            crmd[`DATF] <= wdata[`DATF];
            crmd[`DATM] <= wdata[`DATM];
        end
        else if (excp_commit)
        begin
            crmd[`PLV] <= 2'b00;
            crmd[`IE] <= 1'b0;
        end
        else if (ertn_commit)
        begin
            crmd[`PLV] <= prmd[`PPLV];
            crmd[`IE] <= prmd[`PIE];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            prmd <= '0;
            era <= '0;
            badv <= '0;
        end
        else
        begin
            if (we_prmd)
            begin
                prmd[`PPLV] <= wdata[`PPLV];
                prmd[`PIE] <= wdata[`PIE];
            end
            else if (excp_commit)
            begin
                prmd[`PPLV] <= crmd[`PLV];
                prmd[`PIE] <= crmd[`IE];
            end
            if (we_era)
            begin
                era <= wdata;
            end
            else if (excp_commit)
            begin
                era <= excp_era;
            end
            if (excp_commit && use_badv)
            begin
                badv <= bad_vaddr;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            estat <= '0;
        end
        else
        begin
            if (we_estat)
            begin
                estat[`IS_SOFT] <= wdata[`IS_SOFT];
            end
            if (excp_commit)
            begin
                estat[`ECODE] <= excp_ecode;
                estat[`ESUBCODE] <= excp_subcode;
            end
            estat[`IS_HARD] <= intrpt;
            // Fire wins over a clear in the same cycle
            if (ti_fire)
            begin
                estat[`IS_TI] <= 1'b1;
            end
            else if (ti_clear)
            begin
                estat[`IS_TI] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            eentry <= '0;
            ecfg <= '0;
            tid <= '0;
        end
        else
        begin
            if (we_eentry)
            begin
                eentry[`VA] <= wdata[`VA];
            end
            if (we_ecfg)
            begin
                ecfg[`LIE_9_0] <= wdata[`LIE_9_0];
                ecfg[`LIE_12_11] <= wdata[`LIE_12_11];
            end
            if (we_tid)
            begin
                tid <= wdata;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (rst)
            begin
                save[i] <= '0;
            end
            else if (wen && (waddr == csr_addr_t'(`SAVE0 + i)))
            begin
                save[i] <= wdata;
            end
        end
    end

    a_jump_has_commit: assert property (
        @(posedge clk) disable iff (rst) excp_jump |-> (excp_commit ^ ertn_commit)
    ) else $error("redirect without a single commit");

    a_ertn_restore: assert property (
        @(posedge clk) disable iff (rst)
        ertn_commit |=> crmd[`PLV] == $past(prmd[`PPLV]) && crmd[`IE] == $past(prmd[`PIE])
    ) else $error("return did not restore PLV and IE");

endmodule

`default_nettype wire

// File: verilog/csr_timer.sv
`default_nettype none
`include "csr_macros.svh"

module csr_timer (
    input  logic               clk,
    input  logic               rst,
    input  logic               tcfg_we,
    input  csr_pkg::csr_word_t wdata,
    output csr_pkg::csr_word_t tcfg,
    output csr_pkg::csr_word_t tval,
    output logic [63:0]        timer_64,
    output logic               ti_fire
);

    logic timer_en;
    logic tval_zero;

    assign tval_zero = (tval == '0);
    assign ti_fire = timer_en && tval_zero;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tcfg <= '0;
        end
        else if (tcfg_we)
        begin
            tcfg[`EN] <= wdata[`EN];
            tcfg[`PERIODIC] <= wdata[`PERIODIC];
            tcfg[`INITVAL] <= wdata[`INITVAL];
        end
    end

    // One-shot timer stops after firing
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            timer_en <= 1'b0;
        end
        else if (tcfg_we)
        begin
            timer_en <= wdata[`EN];
        end
        else if (ti_fire)
        begin
            timer_en <= tcfg[`PERIODIC];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tval <= '0;
        end
        else if (tcfg_we)
        begin
            tval <= {wdata[`INITVAL], 2'b00};
        end
        else if (timer_en)
        begin
            if (!tval_zero)
            begin
                tval <= tval - 1'b1;
            end
            else
            begin
                tval <= tcfg[`PERIODIC] ? {tcfg[`INITVAL], 2'b00} : '0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            timer_64 <= '0;
        end
        else
        begin
            timer_64 <= timer_64 + 64'd1;
        end
    end

    a_fire_at_zero: assert property (
        @(posedge clk) disable iff (rst) ti_fire |-> tval == '0
    ) else $error("timer fired with nonzero TVAL");

endmodule

`default_nettype wire

// File: verilog/csr_top.sv
`default_nettype none

module csr_top (
    input  logic                clk,
    input  logic                rst,
    input  csr_pkg::csr_addr_t  rd_addr1,
    input  csr_pkg::csr_addr_t  rd_addr2,
    input  csr_pkg::csr_addr_t  waddr,
    input  logic                wen,
    input  csr_pkg::csr_word_t  wdata,
    input  logic                in_excp,
    input  logic                is_ertn,
    input  csr_pkg::ecode_t     excp_ecode,
    input  csr_pkg::esubcode_t  excp_subcode,
    input  csr_pkg::csr_word_t  excp_era,
    input  logic                use_badv,
    input  csr_pkg::csr_word_t  bad_vaddr,
    input  logic [7:0]          intrpt,
    output csr_pkg::csr_word_t  rd_data1,
    output csr_pkg::csr_word_t  rd_data2,
    output logic                excp_jump,
    output csr_pkg::csr_word_t  excp_pc,
    output logic                jump_excp_fail,
    output logic                have_intrpt
);
    import csr_pkg::*;

    logic        excp_commit;
    logic        ertn_commit;
    logic        tcfg_we;
    csr_word_t   tcfg;
    csr_word_t   tval;
    logic [63:0] timer_64;
    logic        ti_fire;

    csr_excp_capture u_excp_capture (
        .clk            (clk),
        .rst            (rst),
        .wen            (wen),
        .in_excp        (in_excp),
        .is_ertn        (is_ertn),
        .excp_commit    (excp_commit),
        .ertn_commit    (ertn_commit),
        .jump_excp_fail (jump_excp_fail),
        .excp_jump      (excp_jump)
    );

    csr_timer u_timer (
        .clk      (clk),
        .rst      (rst),
        .tcfg_we  (tcfg_we),
        .wdata    (wdata),
        .tcfg     (tcfg),
        .tval     (tval),
        .timer_64 (timer_64),
        .ti_fire  (ti_fire)
    );

    csr_regfile u_regfile (
        .clk          (clk),
        .rst          (rst),
        .rd_addr1     (rd_addr1),
        .rd_addr2     (rd_addr2),
        .wen          (wen),
        .waddr        (waddr),
        .wdata        (wdata),
        .excp_commit  (excp_commit),
        .ertn_commit  (ertn_commit),
        .excp_jump    (excp_jump),
        .excp_ecode   (excp_ecode),
        .excp_subcode (excp_subcode),
        .excp_era     (excp_era),
        .use_badv     (use_badv),
        .bad_vaddr    (bad_vaddr),
        .intrpt       (intrpt),
        .tcfg         (tcfg),
        .tval         (tval),
        .timer_64     (timer_64),
        .ti_fire      (ti_fire),
        .rd_data1     (rd_data1),
        .rd_data2     (rd_data2),
        .tcfg_we      (tcfg_we),
        .excp_pc      (excp_pc),
        .have_intrpt  (have_intrpt)
    );

endmodule

`default_nettype wire
